/* sources.f */
hdl/isaPkg.sv
hdl/cpuPkg.sv
hdl/Control.sv
hdl/RegFile.sv
hdl/Alu.sv
hdl/DataMem.sv
hdl/FetchUnit.sv
hdl/TopLevel.sv
test/TopLevel_tb.sv

/* Bender.yml */
package:
  name: single_cycle_cpu

sources:
  - files:
      - hdl/isaPkg.sv
      - hdl/cpuPkg.sv
      - hdl/Control.sv
      - hdl/RegFile.sv
      - hdl/Alu.sv
      - hdl/DataMem.sv
      - hdl/FetchUnit.sv
      - hdl/TopLevel.sv
  - target: test
    files:
      - test/TopLevel_tb.sv

/* test/TopLevel_tb.sv */
// directed testbench for the processor top, loads short programs and checks the store bus
`timescale 1ns/100ps
`default_nettype none

module TopLevel_tb;

  localparam real         CLK_PERIOD   = 4.0;
  localparam real         DRIVE_DELAY  = 1.0;   // after the rising edge
  localparam int          RESET_CYCLES = 3;
  localparam int          PROG_MAX     = 128;   // longest program a test builds
  localparam int          RUN_LIMIT    = 200;   // cycles allowed until halted
  localparam int          HOLD_CYCLES  = 5;     // cycles watched after halt
  localparam int          RUN_COUNT    = 7;     // program runs over all tests
  localparam int          RUN_CYCLES   = RESET_CYCLES + PROG_MAX + RUN_LIMIT + HOLD_CYCLES + 3;
  localparam real         TIMEOUT      = RUN_COUNT * RUN_CYCLES * CLK_PERIOD + 100.0;
  localparam int unsigned SEED         = 32'h75344797;

  typedef struct packed {
    logic [cpuPkg::DATA_W-1:0] addr;
    logic [cpuPkg::DATA_W-1:0] data;
  } storeS;

  logic                         clk;
  logic                         rst;
  logic                         imemWe;
  logic [isaPkg::PC_W-1:0]      imemAddr;
  logic [isaPkg::INSTR_W-1:0]   imemData;
  logic [isaPkg::PC_W-1:0]      pc;
  logic                         halted;
  logic                         storeValid;
  logic [cpuPkg::DATA_W-1:0]    storeAddr;
  logic [cpuPkg::DATA_W-1:0]    storeData;

  logic [isaPkg::INSTR_W-1:0]   prog [$];
  storeS                        expStores [$];
  storeS                        gotStores [$];
  int                           errors;
  int                           testErrors;
  int                           testCount;
  int                           badTests;

  TopLevel dut_i (
    .clk, .rst, .imemWe, .imemAddr, .imemData,
    .pc, .halted, .storeValid, .storeAddr, .storeData
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [8:0] rWord(isaPkg::opcodeE op, logic [1:0] funct, logic [3:0] rd);
    return {op, funct, rd};
  endfunction

  function automatic logic [8:0] iWord(isaPkg::opcodeE op, logic [4:0] immed, logic sel);
    return {op, immed, sel};
  endfunction

  // destination select in bit 5, source register in bits 4..1
  function automatic logic [8:0] moveWord(logic dst, logic [3:0] src);
    return {isaPkg::move, dst, src, 1'b0};
  endfunction

  function automatic logic [8:0] branchWord(logic signed [5:0] offset);
    return {isaPkg::branch, offset};
  endfunction

  function automatic logic [8:0] haltWord();
    return rWord(isaPkg::rType2, isaPkg::FUNCT_HALT, 4'd0);
  endfunction

  function automatic logic [7:0] lutAddr(logic [4:0] idx);
    return 8'(idx * 8);  // lb / sb entries sit eight bytes apart
  endfunction

  task automatic emit(input logic [8:0] word);
    prog.push_back(word);
  endtask

  task automatic expectStore(input logic [7:0] addr, input logic [7:0] data);
    expStores.push_back(storeS'({addr, data}));
  endtask

  // R0 = value from the zero in R15 and a chain of addi
  task automatic setR0(input logic [7:0] value);
    int left;
    left = value;
    emit(moveWord(1'b0, 4'd15));
    while (left > 0) begin
      emit(iWord(isaPkg::addi, (left > 31) ? 5'd31 : 5'(left), 1'b0));
      left -= (left > 31) ? 31 : left;
    end
  endtask

  task automatic setR0R1(input logic [7:0] a, input logic [7:0] b);
    setR0(b);
    emit(moveWord(1'b1, 4'd0));  // R1 = b
    setR0(a);
  endtask

  // register-addressed store of R[r] to addr that clobbers R0
  task automatic storeRegAt(input logic [3:0] r, input logic [7:0] addr, input logic [7:0] data);
    setR0(addr);
    emit(rWord(isaPkg::rType0, isaPkg::FUNCT_STORE, r));
    expectStore(addr, data);
  endtask

  task automatic compareValue(input string name, input string what,
                              input logic [15:0] expVal, input logic [15:0] actVal);
    assert (expVal === actVal) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", name, what, expVal, actVal);
      testErrors++;
    end
  endtask

  task automatic checkTrue(input string name, input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("%s: %s", name, msg);
      testErrors++;
    end
  endtask

  task automatic startTest();
    testErrors = 0;
    prog.delete();
    expStores.delete();
  endtask

  task automatic finishTest(input string name);
    testCount++;
    errors += testErrors;
    if (testErrors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, testErrors);
      badTests++;
    end
  endtask

  // reset, load prog while held, run until halted and compare the stores
  task automatic runProgram(input string name, input int haltPc);
    int                      cycles;
    logic [isaPkg::PC_W-1:0] frozenPc;
    checkTrue(name, prog.size() <= PROG_MAX, "program is longer than the load budget");
    gotStores.delete();
    @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    for (int i = 0; i < prog.size(); i++) begin
      #(DRIVE_DELAY);
      imemWe   = 1'b1;
      imemAddr = isaPkg::PC_W'(i);
      imemData = prog[i];
      @(posedge clk);
    end
    #(DRIVE_DELAY);
    imemWe = 1'b0;
    rst    = 1'b0;
    @(negedge clk);
    compareValue(name, "pc after reset", 16'd0, 16'(pc));
    checkTrue(name, !halted, "halted is set right after reset");
    checkTrue(name, !storeValid, "store strobe is high in the first cycle after reset");
    cycles = 0;
    while (halted !== 1'b1 && cycles < RUN_LIMIT) begin
      if (storeValid) gotStores.push_back(storeS'({storeAddr, storeData}));
      @(negedge clk);
      cycles++;
    end
    checkTrue(name, halted, "halted was never set within the cycle limit");
    if (halted === 1'b1) begin
      frozenPc = pc;
      if (haltPc >= 0) compareValue(name, "pc at halt", 16'(haltPc), 16'(pc));
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        compareValue(name, "pc after halt", 16'(frozenPc), 16'(pc));
        checkTrue(name, !storeValid, "a store appeared after halt");
      end
    end
    compareValue(name, "store count", 16'(expStores.size()), 16'(gotStores.size()));
    for (int i = 0; i < expStores.size() && i < gotStores.size(); i++) begin
      compareValue(name, $sformatf("store %0d address", i), 16'(expStores[i].addr),
                   16'(gotStores[i].addr));
      compareValue(name, $sformatf("store %0d data", i), 16'(expStores[i].data),
                   16'(gotStores[i].data));
    end
  endtask

  task automatic arithTest();
    logic [7:0] a;
    logic [7:0] b;
    logic [4:0] k;
    startTest();
    a = 8'($urandom);
    b = 8'($urandom);
    k = 5'($urandom);
    setR0R1(a, b);
    emit(rWord(isaPkg::rType0, isaPkg::FUNCT_ADD, 4'd2));
    emit(rWord(isaPkg::rType0, isaPkg::FUNCT_SUB, 4'd3));
    emit(iWord(isaPkg::addi, k, 1'b0));
    emit(iWord(isaPkg::sb, 5'd1, 1'b0));  // R0 + k out through lut entry 1
    expectStore(lutAddr(5'd1), 8'(a + k));
    storeRegAt(4'd2, 8'h40, 8'(a + b));
    storeRegAt(4'd3, 8'h41, 8'(a - b));
    emit(haltWord());
    runProgram("arith", -1);
    finishTest("arith");
  endtask

  task automatic shiftLogicTest();
    logic [7:0] a;
    logic [7:0] b;
    logic [2:0] s;
    logic [7:0] want [2:8];
    startTest();
    a = 8'($urandom) | 8'h80;  // negative so asr must fill with ones
    b = (8'($urandom) & 8'hf8) | 8'(1 + $urandom % 7);
    s = b[2:0];
    want[2] = 8'(a << s);
    want[3] = (a >> s) | ~(8'hff >> s);
    want[4] = a >> s;
    want[5] = ~a;
    want[6] = a & b;
    want[7] = a | b;
    want[8] = 8'(a * b);
    setR0R1(a, b);
    emit(rWord(isaPkg::rType1, isaPkg::FUNCT_LSL, 4'd2));
    emit(rWord(isaPkg::rType1, isaPkg::FUNCT_ASR, 4'd3));
    emit(rWord(isaPkg::rType1, isaPkg::FUNCT_LSR, 4'd4));
    emit(rWord(isaPkg::rType1, isaPkg::FUNCT_NOT, 4'd5));
    emit(rWord(isaPkg::rType2, isaPkg::FUNCT_AND, 4'd6));
    emit(rWord(isaPkg::rType2, isaPkg::FUNCT_OR, 4'd7));
    emit(rWord(isaPkg::rType2, isaPkg::FUNCT_MUL, 4'd8));
    for (int r = 2; r <= 8; r++) begin
      storeRegAt(4'(r), 8'(8'h80 + r), want[r]);
    end
    emit(haltWord());
    runProgram("shiftLogic", -1);
    finishTest("shiftLogic");
  endtask

  task automatic memoryTest();
    logic [7:0] addrX;
    logic [7:0] v;
    logic [7:0] w;
    logic [4:0] idx;
    startTest();
    addrX = 8'($urandom);
    v     = 8'($urandom);
    w     = v ^ 8'h5a;
    idx   = 5'($urandom);
    setR0R1(addrX, v);
    emit(rWord(isaPkg::rType0, isaPkg::FUNCT_STORE, 4'd1));  // mem[R0] = R1
    expectStore(addrX, v);
    emit(rWord(isaPkg::rType0, isaPkg::FUNCT_LOAD, 4'd4));   // R4 = mem[R0]
    storeRegAt(4'd4, addrX ^ 8'h80, v);
    setR0(w);
    emit(iWord(isaPkg::sb, idx, 1'b0));
    expectStore(lutAddr(idx), w);
    emit(iWord(isaPkg::lb, idx, 1'b1));  // R1 picks up w
    emit(iWord(isaPkg::sb, idx ^ 5'd1, 1'b1));
    expectStore(lutAddr(idx ^ 5'd1), w);
    emit(haltWord());
    runProgram("memory", -1);
    finishTest("memory");
  endtask

  task automatic moveTest();
    logic [7:0] a;
    logic [7:0] b;
    logic [3:0] srcA;
    logic [3:0] srcB;
    startTest();
    a    = 8'($urandom);
    b    = 8'($urandom);
    srcA = 4'(2 + $urandom % 13);
    srcB = (srcA == 4'd14) ? 4'd2 : srcA + 4'd1;
    setR0R1(a, b);
    emit(rWord(isaPkg::rType0, isaPkg::FUNCT_ADD, srcA));
    emit(rWord(isaPkg::rType0, isaPkg::FUNCT_SUB, srcB));
    emit(moveWord(1'b1, srcA));
    emit(moveWord(1'b0, srcB));
    emit(iWord(isaPkg::sb, 5'd2, 1'b1));
    expectStore(lutAddr(5'd2), 8'(a + b));
    emit(iWord(isaPkg::sb, 5'd3, 1'b0));
    expectStore(lutAddr(5'd3), 8'(a - b));
    emit(moveWord(1'b0, 4'd1));  // R0 = R1
    emit(iWord(isaPkg::sb, 5'd4, 1'b0));
    expectStore(lutAddr(5'd4), 8'(a + b));
    emit(haltWord());
    runProgram("move", -1);
    finishTest("move");
  endtask

  task automatic branchTest();
    startTest();
    emit(moveWord(1'b0, 4'd15));           // 0: R0 = 0
    emit(branchWord(6'sd3));               // 1: taken to 4
    emit(iWord(isaPkg::sb, 5'd5, 1'b0));   // 2: skipped
    emit(iWord(isaPkg::sb, 5'd6, 1'b0));   // 3: skipped
    emit(iWord(isaPkg::addi, 5'd7, 1'b0)); // 4
    emit(branchWord(6'sd2));               // 5: R0 is 7 so it falls through
    emit(iWord(isaPkg::sb, 5'd7, 1'b0));   // 6
    emit(moveWord(1'b0, 4'd15));           // 7
    emit(branchWord(6'sd2));               // 8: taken to 10
    emit(iWord(isaPkg::addi, 5'd1, 1'b0)); // 9: skipped
    emit(iWord(isaPkg::sb, 5'd9, 1'b0));   // 10
    emit(haltWord());                      // 11
    expectStore(lutAddr(5'd7), 8'd7);
    expectStore(lutAddr(5'd9), 8'd0);
    runProgram("branch", 11);
    finishTest("branch");
  endtask

  // second run shows reset cleared pc, halted, registers and data memory
  task automatic resetHaltTest();
    startTest();
    emit(iWord(isaPkg::addi, 5'd3, 1'b0));
    emit(iWord(isaPkg::lb, 5'd10, 1'b1));
    emit(iWord(isaPkg::sb, 5'd12, 1'b1));
    emit(iWord(isaPkg::sb, 5'd10, 1'b0));
    emit(haltWord());
    emit(iWord(isaPkg::sb, 5'd11, 1'b0));  // behind the halt and never runs
    expectStore(lutAddr(5'd12), 8'd0);
    expectStore(lutAddr(5'd10), 8'd3);
    runProgram("resetHalt", 4);
    runProgram("resetHalt", 4);
    finishTest("resetHalt");
  endtask

  initial begin
    rst        = 1'b1;
    imemWe     = 1'b0;
    imemAddr   = '0;
    imemData   = '0;
    errors     = 0;
    testErrors = 0;
    testCount  = 0;
    badTests   = 0;
    void'($urandom(SEED));
    arithTest();
    shiftLogicTest();
    memoryTest();
    moveTest();
    branchTest();
    resetHaltTest();
    $display("summary: %0d tests, %0d with errors, %0d failing checks",
             testCount, badTests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // backstop in case a wait above never returns
  initial begin
    #(TIMEOUT);
    $display("watchdog: the run did not finish within %0t", $realtime);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/TopLevel.sv */
// single-cycle processor top, connects fetch, decode, register file, ALU and data memory
`timescale 1ns/100ps
`default_nettype none

module TopLevel (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         imemWe,
  input  logic [isaPkg::PC_W-1:0]      imemAddr,
  input  logic [isaPkg::INSTR_W-1:0]   imemData,
  output logic [isaPkg::PC_W-1:0]      pc,
  output logic                         halted,
  output logic                         storeValid,
  output logic [cpuPkg::DATA_W-1:0]    storeAddr,
  output logic [cpuPkg::DATA_W-1:0]    storeData
);

  isaPkg::instrU              instr;
  cpuPkg::ctrlS               ctrl;
  logic [cpuPkg::REG_AW-1:0]  regA;
  logic [cpuPkg::REG_AW-1:0]  regB;
  logic [cpuPkg::REG_AW-1:0]  wrAddr;
  logic [cpuPkg::DATA_W-1:0]  datA;
  logic [cpuPkg::DATA_W-1:0]  datB;
  logic [cpuPkg::DATA_W-1:0]  datIn;
  logic [cpuPkg::DATA_W-1:0]  memIn;
  logic [cpuPkg::DATA_W-1:0]  memAddr;
  logic [cpuPkg::DATA_W-1:0]  memOut;
  logic [cpuPkg::DATA_W-1:0]  lutOut;
  logic [cpuPkg::DATA_W-1:0]  aluA;
  logic [cpuPkg::DATA_W-1:0]  aluB;
  logic [cpuPkg::DATA_W-1:0]  aluResult;
  logic [cpuPkg::LUT_AW-1:0]  lutIdx;

  FetchUnit fetch_i (
    .clk, .rst, .imemWe, .imemAddr, .imemData,
    .branch (ctrl.branch),
    .halt   (ctrl.halt),
    .datA, .instr, .pc, .halted
  );

  Control control_i (
    .instr, .datA, .datB, .memOut, .lutOut, .aluResult,
    .ctrl, .regA, .regB, .wrAddr, .datIn, .memIn, .memAddr,
    .aluA, .aluB, .lutIdx
  );

  RegFile regFile_i (
    .clk, .rst, .regA, .regB, .wrAddr,
    .regWrite (ctrl.regWrite),
    .datIn, .datA, .datB
  );

  Alu alu_i (
    .aluA, .aluB,
    .aluOp (ctrl.aluOp),
    .aluResult
  );

  DataMem dataMem_i (
    .clk, .rst, .memAddr, .memIn,
    .memWrite (ctrl.memWrite),
    .lutIdx, .memOut, .lutOut
  );

  // store bus mirrors the memory write port
  assign storeValid = ctrl.memWrite;
  assign storeAddr  = memAddr;
  assign storeData  = memIn;

endmodule

`default_nettype wire

/* hdl/FetchUnit.sv */
// program counter and instruction memory, loaded through a write port while in reset
`timescale 1ns/100ps
`default_nettype none

module FetchUnit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         imemWe,
  input  logic [isaPkg::PC_W-1:0]      imemAddr,
  input  logic [isaPkg::INSTR_W-1:0]   imemData,
  input  logic                         branch,
  input  logic                         halt,
  input  logic [cpuPkg::DATA_W-1:0]    datA,
  output isaPkg::instrU                instr,
  output logic [isaPkg::PC_W-1:0]      pc,
  output logic                         halted
);

  logic [isaPkg::INSTR_W-1:0] imem [isaPkg::IMEM_DEPTH];
  logic [5:0]                 offset;      // signed branch offset, bits 5..0
  logic [isaPkg::PC_W-1:0]    branchTarget;

  // program survives reset, only the load port writes it
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  assign instr        = imem[pc];
  assign offset       = {instr.iView.immed, instr.iView.sel};
  assign branchTarget = pc + {{(isaPkg::PC_W - 6){offset[5]}}, offset};

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (halt || halted) begin
      halted <= 1'b1;  // pc holds from here on
    end else if (branch && datA == '0) begin
      pc <= branchTarget;  // taken when R0 is zero
    end else begin
      pc <= pc + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/DataMem.sv */
// data memory with asynchronous read, clocked write and the lb / sb address table
`timescale 1ns/100ps
`default_nettype none

module DataMem (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [cpuPkg::DATA_W-1:0]   memAddr,
  input  logic [cpuPkg::DATA_W-1:0]   memIn,
  input  logic                        memWrite,
  input  logic [cpuPkg::LUT_AW-1:0]   lutIdx,
  output logic [cpuPkg::DATA_W-1:0]   memOut,
  output logic [cpuPkg::DATA_W-1:0]   lutOut
);

  logic [cpuPkg::DATA_W-1:0] mem [cpuPkg::MEM_DEPTH];
  logic [cpuPkg::DATA_W-1:0] lut [cpuPkg::LUT_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpuPkg::MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (memWrite) begin
      mem[memAddr] <= memIn;
    end
  end

  // fixed table, entry i points at i * stride
  always_comb begin
    for (int i = 0; i < cpuPkg::LUT_DEPTH; i++) begin
      lut[i] = cpuPkg::DATA_W'(i * cpuPkg::LUT_STRIDE);
    end
  end

  assign memOut = mem[memAddr];
  assign lutOut = lut[lutIdx];

endmodule

`default_nettype wire

/* hdl/Alu.sv */
// combinational 8-bit ALU of the core
`timescale 1ns/100ps
`default_nettype none

module Alu (
  input  logic [cpuPkg::DATA_W-1:0] aluA,
  input  logic [cpuPkg::DATA_W-1:0] aluB,
  input  cpuPkg::aluOpE             aluOp,
  output logic [cpuPkg::DATA_W-1:0] aluResult
);

  logic [2:0] shamt;  // shifts only look at the low bits of b

  assign shamt = aluB[2:0];

  always_comb begin
    case (aluOp)
      cpuPkg::add:    aluResult = aluA + aluB;
      cpuPkg::sub:    aluResult = aluA - aluB;
      cpuPkg::lsl:    aluResult = aluA << shamt;
      cpuPkg::asr:    aluResult = cpuPkg::DATA_W'($signed(aluA) >>> shamt);  // sign fill
      cpuPkg::lsr:    aluResult = aluA >> shamt;
      cpuPkg::bitNot: aluResult = ~aluA;
      cpuPkg::bitAnd: aluResult = aluA & aluB;
      cpuPkg::bitOr:  aluResult = aluA | aluB;
      cpuPkg::mul:    aluResult = aluA * aluB;  // low byte of the product
      cpuPkg::passA:  aluResult = aluA;
      default:        aluResult = aluA;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/RegFile.sv */
// register file of the core, two asynchronous read ports and one clocked write port
`timescale 1ns/100ps
`default_nettype none

module RegFile (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [cpuPkg::REG_AW-1:0]   regA,
  input  logic [cpuPkg::REG_AW-1:0]   regB,
  input  logic [cpuPkg::REG_AW-1:0]   wrAddr,
  input  logic                        regWrite,
  input  logic [cpuPkg::DATA_W-1:0]   datIn,
  output logic [cpuPkg::DATA_W-1:0]   datA,
  output logic [cpuPkg::DATA_W-1:0]   datB
);

  logic [cpuPkg::DATA_W-1:0] regs [cpuPkg::REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpuPkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite) begin
      regs[wrAddr] <= datIn;
    end
  end

  // reads see the old value during a write cycle
  assign datA = regs[regA];
  assign datB = regs[regB];

endmodule

`default_nettype wire

/* hdl/Control.sv */
// instruction decoder, drives control signals and the datapath muxes of the core
`timescale 1ns/100ps
`default_nettype none

module Control (
  input  isaPkg::instrU                instr,
  input  logic [cpuPkg::DATA_W-1:0]    datA,
  input  logic [cpuPkg::DATA_W-1:0]    datB,
  input  logic [cpuPkg::DATA_W-1:0]    memOut,
  input  logic [cpuPkg::DATA_W-1:0]    lutOut,
  input  logic [cpuPkg::DATA_W-1:0]    aluResult,
  output cpuPkg::ctrlS                 ctrl,
  output logic [cpuPkg::REG_AW-1:0]    regA,
  output logic [cpuPkg::REG_AW-1:0]    regB,
  output logic [cpuPkg::REG_AW-1:0]    wrAddr,
  output logic [cpuPkg::DATA_W-1:0]    datIn,
  output logic [cpuPkg::DATA_W-1:0]    memIn,
  output logic [cpuPkg::DATA_W-1:0]    memAddr,
  output logic [cpuPkg::DATA_W-1:0]    aluA,
  output logic [cpuPkg::DATA_W-1:0]    aluB,
  output logic [cpuPkg::LUT_AW-1:0]    lutIdx
);

  logic memToReg;  // write back memory data instead of alu result
  logic aluSrc;    // immediate as second alu operand
  logic memSrc;    // address from lookup table instead of R0

  always_comb begin
    ctrl.regWrite = 1'b1;
    ctrl.memWrite = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.halt     = 1'b0;
    ctrl.aluOp    = cpuPkg::passA;
    regA          = '0;  // R0
    regB          = cpuPkg::REG_AW'(1);  // R1
    wrAddr        = instr.rView.rd;
    memToReg      = 1'b0;
    aluSrc        = 1'b0;
    memSrc        = 1'b0;

    case (instr.rView.opcode)
      isaPkg::rType0: begin
        case (instr.rView.funct)
          isaPkg::FUNCT_ADD:  ctrl.aluOp = cpuPkg::add;
          isaPkg::FUNCT_SUB:  ctrl.aluOp = cpuPkg::sub;
          isaPkg::FUNCT_LOAD: memToReg = 1'b1;  // rd = mem[R0]
          isaPkg::FUNCT_STORE: begin
            regB          = instr.rView.rd;  // store data comes from rd
            ctrl.memWrite = 1'b1;
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      isaPkg::lb: begin
        wrAddr   = {3'b0, instr.iView.sel};
        memSrc   = 1'b1;
        memToReg = 1'b1;
      end
      isaPkg::sb: begin
        regB          = {3'b0, instr.iView.sel};
        memSrc        = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.regWrite = 1'b0;
      end
      isaPkg::addi: begin
        wrAddr     = '0;
        aluSrc     = 1'b1;
        ctrl.aluOp = cpuPkg::add;
      end
      isaPkg::branch: begin
        ctrl.branch   = 1'b1;  // fetch tests R0 on datA
        ctrl.regWrite = 1'b0;
      end
      isaPkg::move: begin
        // source in bits 4..1, destination select in bit 5
        regA   = instr.iView.immed[3:0];
        wrAddr = {3'b0, instr.iView.immed[4]};
      end
      isaPkg::rType1: begin
        case (instr.rView.funct)
          isaPkg::FUNCT_LSL: ctrl.aluOp = cpuPkg::lsl;
          isaPkg::FUNCT_ASR: ctrl.aluOp = cpuPkg::asr;
          isaPkg::FUNCT_LSR: ctrl.aluOp = cpuPkg::lsr;
          isaPkg::FUNCT_NOT: ctrl.aluOp = cpuPkg::bitNot;
        endcase
      end
      isaPkg::rType2: begin
        case (instr.rView.funct)
          isaPkg::FUNCT_AND: ctrl.aluOp = cpuPkg::bitAnd;
          isaPkg::FUNCT_OR:  ctrl.aluOp = cpuPkg::bitOr;
          isaPkg::FUNCT_MUL: ctrl.aluOp = cpuPkg::mul;
          isaPkg::FUNCT_HALT: begin
            ctrl.halt     = 1'b1;  // no side effects while halted
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
    endcase
  end

  assign lutIdx  = instr.iView.immed;
  assign aluA    = datA;
  assign aluB    = aluSrc ? cpuPkg::DATA_W'(instr.iView.immed) : datB;
  assign memAddr = memSrc ? lutOut : datA;
  assign memIn   = datB;
  assign datIn   = memToReg ? memOut : aluResult;

endmodule

`default_nettype wire

/* hdl/cpuPkg.sv */
// datapath widths, ALU operations and control bundle used across the processor core
`default_nettype none

package cpuPkg;

  localparam int DATA_W    = 8;
  localparam int REG_COUNT = 16;
  localparam int REG_AW    = $clog2(REG_COUNT);  // register index width
  localparam int MEM_DEPTH = 2 ** DATA_W;        // data memory is fully addressed by a byte
  localparam int LUT_DEPTH = 32;
  localparam int LUT_AW    = $clog2(LUT_DEPTH);

  // lookup table rule: entry i holds address i * LUT_STRIDE
  localparam int LUT_STRIDE = 8;

  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    lsl    = 4'd2,
    asr    = 4'd3,
    lsr    = 4'd4,
    bitNot = 4'd5,
    bitAnd = 4'd6,
    bitOr  = 4'd7,
    mul    = 4'd8,
    passA  = 4'd15  // result is operand a
  } aluOpE;

  typedef struct packed {
    logic  regWrite;
    logic  memWrite;
    logic  branch;
    logic  halt;
    aluOpE aluOp;
  } ctrlS;

endpackage

`default_nettype wire

/* hdl/isaPkg.sv */
// instruction set definitions, shared by the decoder, the fetch unit and the testbench
`default_nettype none

package isaPkg;

  localparam int INSTR_W    = 9;                   // instruction word width
  localparam int IMEM_DEPTH = 256;                 // instruction memory words
  localparam int PC_W       = $clog2(IMEM_DEPTH);  // pc width

  typedef enum logic [2:0] {
    rType0 = 3'b000,  // add, sub, register load / store
    lb     = 3'b001,
    sb     = 3'b010,
    addi   = 3'b011,
    branch = 3'b100,
    move   = 3'b101,
    rType1 = 3'b110,  // shifts and not
    rType2 = 3'b111   // logic, mul, halt
  } opcodeE;

  // funct codes, one group per R-type opcode
  localparam logic [1:0] FUNCT_ADD   = 2'b00;
  localparam logic [1:0] FUNCT_SUB   = 2'b01;
  localparam logic [1:0] FUNCT_LOAD  = 2'b10;
  localparam logic [1:0] FUNCT_STORE = 2'b11;
  localparam logic [1:0] FUNCT_LSL   = 2'b00;
  localparam logic [1:0] FUNCT_ASR   = 2'b01;
  localparam logic [1:0] FUNCT_LSR   = 2'b10;
  localparam logic [1:0] FUNCT_NOT   = 2'b11;
  localparam logic [1:0] FUNCT_AND   = 2'b00;
  localparam logic [1:0] FUNCT_OR    = 2'b01;
  localparam logic [1:0] FUNCT_MUL   = 2'b10;
  localparam logic [1:0] FUNCT_HALT  = 2'b11;

  typedef struct packed {
    opcodeE     opcode;
    logic [1:0] funct;
    logic [3:0] rd;     // destination, or source of a register store
  } rViewS;

  typedef struct packed {
    opcodeE     opcode;
    logic [4:0] immed;  // lut index or addi constant
    logic       sel;    // picks R0 or R1
  } iViewS;

  typedef union packed {
    rViewS rView;
    iViewS iView;
  } instrU;

endpackage

`default_nettype wire
